// File: src/streamPkg.sv
/*
  Stream subsystem package
  Shared widths, data types and the source select encoding
*/
package streamPkg;

  // Width of every integer word on the internal and total channels
  localparam int WordWidth = 32;

  // Width of one signed element of the external pair port
  localparam int ElemWidth = 13;

  // Counter values, pair sums and running totals
  typedef logic [WordWidth-1:0] wordT;

  // One element of an input pair, two's complement
  typedef logic signed [ElemWidth-1:0] elemT;

  // Source select for the accumulator
  // SrcCount takes the internal counter, SrcPair the reduced pair stream
  typedef enum logic {
    SrcCount = 1'b0,
    SrcPair  = 1'b1
  } srcT;

endpackage

// File: src/intCounter.sv
/*
  Integer counter source
  Offers an incrementing word stream over a valid/ready channel
*/
module intCounter (
  input  logic            clk,
  input  logic            rstn,
  output logic            cntValid,
  output streamPkg::wordT cntData,
  input  logic            cntReady
);
  import streamPkg::*;

  wordT count;
  logic validQ;
  logic take;

  // Word leaves the counter on this edge
  assign take = validQ && cntReady;

  assign cntValid = validQ;
  assign cntData  = count;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      validQ <= 1'b0;
      count  <= '0;
    end else begin
      // Always has a word to offer once out of reset
      validQ <= 1'b1;
      // Advance only on transfer, so nothing is skipped under back-pressure
      if (take) begin
        count <= count + wordT'(1);
      end
    end
  end

endmodule

// File: src/pairSum.sv
/*
  Pair sum stage
  Sign-extends a pair of signed elements and registers their 32-bit sum
*/
module pairSum (
  input  logic            clk,
  input  logic            rstn,
  input  logic            pairValid,
  input  streamPkg::elemT pairElem0,
  input  streamPkg::elemT pairElem1,
  output logic            pairReady,
  output logic            sumValid,
  output streamPkg::wordT sumData,
  input  logic            sumReady
);
  import streamPkg::*;

  wordT wide0;
  wordT wide1;
  wordT sumNext;
  wordT sumQ;
  logic sumValidQ;
  logic pairTake;
  logic sumTake;

  // Elements are signed, so the size cast sign-extends
  assign wide0   = WordWidth'(pairElem0);
  assign wide1   = WordWidth'(pairElem1);
  assign sumNext = wide0 + wide1;

  // Register empty or being drained on this edge
  assign pairReady = !sumValidQ || sumReady;

  assign pairTake = pairValid && pairReady;
  assign sumTake  = sumValidQ && sumReady;

  assign sumValid = sumValidQ;
  assign sumData  = sumQ;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sumValidQ <= 1'b0;
    end else if (pairTake) begin
      // Refill covers back-to-back transfers
      sumValidQ <= 1'b1;
    end else if (sumTake) begin
      sumValidQ <= 1'b0;
    end
  end

  // Payload register, loaded only with a new pair
  always_ff @(posedge clk) begin
    if (pairTake) begin
      sumQ <= sumNext;
    end
  end

endmodule

// File: src/streamAccumulator.sv
/*
  Stream accumulator
  Takes words from the selected source, keeps a running total modulo 2^32
  and reports the total once per accepted word over a valid/ready channel
*/
module streamAccumulator (
  input  logic            clk,
  input  logic            rstn,
  input  streamPkg::srcT  srcSel,

  // Counter channel
  input  logic            cntValid,
  input  streamPkg::wordT cntData,
  output logic            cntReady,

  // Pair sum channel
  input  logic            sumValid,
  input  streamPkg::wordT sumData,
  output logic            sumReady,

  // Total channel
  output logic            totalValid,
  output streamPkg::wordT totalData,
  input  logic            totalReady
);
  import streamPkg::*;

  // Output holding register state
  typedef enum logic {
    OutEmpty = 1'b0,
    OutFull  = 1'b1
  } outStateT;

  outStateT outState;
  outStateT outStateNext;

  wordT total;
  wordT totalNext;
  wordT inData;
  logic inValid;
  logic inReady;
  logic inTake;
  logic outTake;

  // Input multiplexer

  always_comb begin
    unique case (srcSel)
      SrcPair: begin
        inValid = sumValid;
        inData  = sumData;
      end
      default: begin
        inValid = cntValid;
        inData  = cntData;
      end
    endcase
  end

  // Room for a new result when nothing is held or the held one leaves now
  assign inReady = (outState == OutEmpty) || totalReady;

  // Only the selected source sees ready
  assign cntReady = (srcSel == SrcCount) && inReady;
  assign sumReady = (srcSel == SrcPair) && inReady;

  assign inTake  = inValid && inReady;
  assign outTake = (outState == OutFull) && totalReady;

  // Wraps silently modulo 2^32
  assign totalNext = total + inData;

  // Output FSM

  always_comb begin
    outStateNext = outState;
    unique case (outState)
      OutEmpty: begin
        if (inTake) begin
          outStateNext = OutFull;
        end
      end
      OutFull: begin
        // A new word on the same edge as the take keeps it full
        if (inTake) begin
          outStateNext = OutFull;
        end else if (outTake) begin
          outStateNext = OutEmpty;
        end
      end
      default: begin
        outStateNext = OutEmpty;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      outState <= OutEmpty;
    end else begin
      outState <= outStateNext;
    end
  end

  // Running total, also the held result
  always_ff @(posedge clk) begin
    if (!rstn) begin
      total <= '0;
    end else if (inTake) begin
      total <= totalNext;
    end
  end

  assign totalValid = (outState == OutFull);
  assign totalData  = total;

endmodule

// File: src/streamTop.sv
/*
  Stream subsystem top level
  Counter and pair sum stage feed the accumulator through valid/ready channels
*/
module streamTop (
  input  logic            clk,
  input  logic            rstn,

  // Source select level
  input  streamPkg::srcT  srcSel,

  // External pair port
  input  logic            pairValid,
  input  streamPkg::elemT pairElem0,
  input  streamPkg::elemT pairElem1,
  output logic            pairReady,

  // Running total output
  output logic            totalValid,
  output streamPkg::wordT totalData,
  input  logic            totalReady
);
  import streamPkg::*;

  // Counter channel
  logic cntValid;
  wordT cntData;
  logic cntReady;

  // Sum channel
  logic sumValid;
  wordT sumData;
  logic sumReady;

  intCounter counter (
    .clk      (clk),
    .rstn     (rstn),
    .cntValid (cntValid),
    .cntData  (cntData),
    .cntReady (cntReady)
  );

  pairSum pairStage (
    .clk       (clk),
    .rstn      (rstn),
    .pairValid (pairValid),
    .pairElem0 (pairElem0),
    .pairElem1 (pairElem1),
    .pairReady (pairReady),
    .sumValid  (sumValid),
    .sumData   (sumData),
    .sumReady  (sumReady)
  );

  // Only the source chosen by srcSel is drained
  streamAccumulator accumulator (
    .clk        (clk),
    .rstn       (rstn),
    .srcSel     (srcSel),
    .cntValid   (cntValid),
    .cntData    (cntData),
    .cntReady   (cntReady),
    .sumValid   (sumValid),
    .sumData    (sumData),
    .sumReady   (sumReady),
    .totalValid (totalValid),
    .totalData  (totalData),
    .totalReady (totalReady)
  );

endmodule

// File: tb/streamTop_assert.sv
/*
  Handshake assertions
  Watch the output channels of the accumulator and the pair sum stage
*/
module streamTopAssert (
  input logic            clk,
  input logic            rstn,
  input logic            outValid,
  input streamPkg::wordT outData,
  input logic            outReady,
  input logic            idleReady
);
  timeunit 1ns;
  timeprecision 100ps;

  // A stalled word keeps valid and data until it is taken
  heldStable: assert property (@(posedge clk) disable iff (!rstn)
    (outValid && !outReady) |=> (outValid && $stable(outData)))
    else $error("output word changed or dropped while stalled");

  // Reset empties the output register
  resetEmpty: assert property (@(posedge clk) !rstn |=> !outValid)
    else $error("output valid high in the cycle after reset");

  // Ready towards an unselected source or into a stalled stage stays low
  idleLow: assert property (@(posedge clk) disable iff (!rstn) !idleReady)
    else $error("ready raised where it must stay low");

endmodule

bind streamAccumulator streamTopAssert totalChecks (
  .clk       (clk),
  .rstn      (rstn),
  .outValid  (totalValid),
  .outData   (totalData),
  .outReady  (totalReady),
  .idleReady ((srcSel == streamPkg::SrcCount) ? sumReady : cntReady)
);

bind pairSum streamTopAssert sumChecks (
  .clk       (clk),
  .rstn      (rstn),
  .outValid  (sumValid),
  .outData   (sumData),
  .outReady  (sumReady),
  .idleReady (sumValid && !sumReady && pairReady)
);

// File: tb/streamTop_tb.sv
/*
  Testbench for the stream subsystem
  Runs counter and pair modes under random back-pressure and checks every total
*/
module streamTop_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import streamPkg::*;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 8;
  localparam int CountItems  = 40;
  localparam int PairItems   = 60;
  // Four counter phases, two pair phases and a few directed pairs
  localparam int TotalItems  = 4 * CountItems + 2 * PairItems + 3;

  logic clk;
  logic rstn;
  srcT  srcSel;
  logic pairValid;
  elemT pairElem0;
  elemT pairElem1;
  logic pairReady;
  logic totalValid;
  wordT totalData;
  logic totalReady;

  // Reference model state
  wordT expWords[$];
  wordT expTotal;
  wordT expCount;
  wordT monWord;
  srcT  srcNow;
  int   seenCount;
  // 0 holds totalReady low, 1 holds it high, 2 randomizes it
  int   readyMode;
  int   readyModeSeen;
  int   seedDummy;

  streamTop UUT (
    .clk        (clk),
    .rstn       (rstn),
    .srcSel     (srcSel),
    .pairValid  (pairValid),
    .pairElem0  (pairElem0),
    .pairElem1  (pairElem1),
    .pairReady  (pairReady),
    .totalValid (totalValid),
    .totalData  (totalData),
    .totalReady (totalReady)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic wordT refTotal(input wordT prev, input wordT word);
    return prev + word;
  endfunction

  // Sign-extended sum of one pair
  function automatic wordT pairWord(input elemT e0, input elemT e1);
    int wide0;
    int wide1;
    wide0 = e0;
    wide1 = e1;
    return wordT'(wide0 + wide1);
  endfunction

  // Random element, extremes picked often
  function automatic elemT pickElem();
    int pick;
    pick = $urandom_range(0, 7);
    if (pick == 0) begin
      return elemT'(-4096);
    end else if (pick == 1) begin
      return elemT'(4095);
    end
    return elemT'($urandom);
  endfunction

  task automatic stopOnError(input string what);
    $display("%0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic checkTotal(input wordT actual, input wordT expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: total expected %h, got %h", $time, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkIdle(input logic validSeen, input logic readySeen);
    if (validSeen !== 1'b0 || readySeen !== 1'b1) begin
      $display("[ERROR] %0t ns: after reset expected totalValid 0 and pairReady 1, got %b and %b",
               $time, validSeen, readySeen);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic waitTotals(input int count);
    int target;
    target = seenCount + count;
    wait (seenCount >= target);
    #2;
  endtask

  // Offer one pair and hold it until the stage takes it
  task automatic sendPair(input elemT e0, input elemT e1, input bit gaps);
    logic taken;
    int   idle;
    idle = gaps ? $urandom_range(0, 2) : 0;
    if (idle > 0) begin
      pairValid = 1'b0;
    end
    repeat (idle) nextCycle();
    pairElem0 = e0;
    pairElem1 = e1;
    pairValid = 1'b1;
    do begin
      @(posedge clk);
      taken = pairReady;
      #2;
    end while (!taken);
    expWords.push_back(pairWord(e0, e1));
  endtask

  task automatic sendPairs(input int count, input bit gaps);
    for (int i = 0; i < count; i++) begin
      sendPair(pickElem(), pickElem(), gaps);
    end
    pairValid = 1'b0;
    wait (expWords.size() == 0);
    #2;
    // Both stages drain within the two-cycle pair latency
    repeat (2) nextCycle();
    if (totalValid !== 1'b0) begin
      stopOnError("a total is pending after every pair transferred has been seen");
    end
  endtask

  task automatic toPairMode();
    int target;
    readyMode = 1;
    srcSel = SrcPair;
    // The counter total still held leaves before any pair total
    if (totalValid) begin
      target = seenCount + 1;
      wait (seenCount >= target);
      #2;
    end
    srcNow = SrcPair;
  endtask

  // Back-pressure on the total channel, mode sampled at the edge
  always begin
    @(posedge clk);
    readyModeSeen = readyMode;
    #2;
    if (readyModeSeen == 2) begin
      totalReady = $urandom_range(0, 1);
    end else begin
      totalReady = (readyModeSeen == 1);
    end
  end

  // Monitor on the total channel
  always @(posedge clk) begin
    if (rstn && totalValid && totalReady) begin
      if (srcNow == SrcPair && expWords.size() == 0) begin
        stopOnError("a total was sent with no pair sum pending");
      end else begin
        if (srcNow == SrcCount) begin
          monWord = expCount;
          expCount = expCount + wordT'(1);
        end else begin
          monWord = expWords.pop_front();
        end
        expTotal = refTotal(expTotal, monWord);
        seenCount++;
        checkTotal(totalData, expTotal);
      end
    end
  end

  initial begin
    #((TotalItems * 20 + 4 * ResetCycles) * ClkPeriod);
    stopOnError("the run timed out before all totals were seen");
  end

  initial begin
    seedDummy = $urandom(32'h6eac);
    rstn = 1'b0;
    srcSel = SrcCount;
    pairValid = 1'b0;
    pairElem0 = '0;
    pairElem1 = '0;
    totalReady = 1'b0;
    readyMode = 0;
    srcNow = SrcCount;
    expTotal = '0;
    expCount = '0;
    seenCount = 0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rstn = 1'b1;
    nextCycle();
    checkIdle(totalValid, pairReady);

    // Counter mode, first without then with back-pressure
    readyMode = 1;
    waitTotals(CountItems);
    readyMode = 2;
    waitTotals(CountItems);

    // Pair mode with extremes, the total wraps below zero
    toPairMode();
    sendPair(elemT'(-4096), elemT'(-4096), 1'b0);
    sendPair(elemT'(4095), elemT'(4095), 1'b0);
    sendPair(elemT'(-4096), elemT'(4095), 1'b0);
    sendPairs(PairItems, 1'b0);
    readyMode = 2;
    sendPairs(PairItems, 1'b1);

    // Back to the counter, which resumes where it stopped
    srcSel = SrcCount;
    srcNow = SrcCount;
    waitTotals(CountItems);

    // Reset in mid-run clears total and counter
    readyMode = 1;
    rstn = 1'b0;
    expTotal = '0;
    expCount = '0;
    repeat (ResetCycles) nextCycle();
    rstn = 1'b1;
    waitTotals(CountItems);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: compile.f
src/streamPkg.sv
src/intCounter.sv
src/pairSum.sv
src/streamAccumulator.sv
src/streamTop.sv
tb/streamTop_assert.sv
tb/streamTop_tb.sv

// File: Bender.yml
package:
  name: streamTop

sources:
  # RTL in compile order
  - files:
      - src/streamPkg.sv
      - src/intCounter.sv
      - src/pairSum.sv
      - src/streamAccumulator.sv
      - src/streamTop.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/streamTop_assert.sv
      - tb/streamTop_tb.sv
